// ==== mem_map_pkg.sv ====
`default_nettype none

package mem_map_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // address widths

   localparam int CODE_AW = 10;              // 1k bytes of code space
   localparam int REG_AW  = 9;

   // r0..r7 sit at the top of the register address space
   localparam logic [5:0] REG_BANK_BASE = 6'h3f;

   ////////////////////////////////////////////////////////////////////////////
   // serial loader

   localparam int UART_CLKS_PER_BIT = 104;
   localparam int LOAD_BYTES        = 32;    // program image size

endpackage

`default_nettype wire

// ==== cpu_isa_pkg.sv ====
`default_nettype none

package cpu_isa_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // full-byte opcodes

   localparam logic [7:0] OP_LJMP   = 8'h02; // ljmp addr16
   localparam logic [7:0] OP_INCA   = 8'h04;
   localparam logic [7:0] OP_RRC    = 8'h13;
   localparam logic [7:0] OP_DECA   = 8'h14;
   localparam logic [7:0] OP_RL     = 8'h23;
   localparam logic [7:0] OP_ADDAI  = 8'h24; // add a,#imm
   localparam logic [7:0] OP_RLC    = 8'h33;
   localparam logic [7:0] OP_ADDCI  = 8'h34; // addc a,#imm
   localparam logic [7:0] OP_JC     = 8'h40;
   localparam logic [7:0] OP_ORLAI  = 8'h44;
   localparam logic [7:0] OP_JNC    = 8'h50;
   localparam logic [7:0] OP_ANLAI  = 8'h54;
   localparam logic [7:0] OP_JZ     = 8'h60;
   localparam logic [7:0] OP_XRLAI  = 8'h64;
   localparam logic [7:0] OP_JNZ    = 8'h70;
   localparam logic [7:0] OP_MOVAI  = 8'h74; // mov a,#imm
   localparam logic [7:0] OP_SJMP   = 8'h80;
   localparam logic [7:0] OP_SUBBAI = 8'h94;
   localparam logic [7:0] OP_CJNEAI = 8'hb4; // cjne a,#imm,rel
   localparam logic [7:0] OP_CLRC   = 8'hc3;
   localparam logic [7:0] OP_SETBC  = 8'hd3;
   localparam logic [7:0] OP_CLRA   = 8'he4;
   localparam logic [7:0] OP_CPLA   = 8'hf4;

   // r-register groups, opcode bits 7:3
   localparam logic [4:0] GRP_INCR  = 5'h01; // 08..0f
   localparam logic [4:0] GRP_DECR  = 5'h03;
   localparam logic [4:0] GRP_ADDAR = 5'h05;
   localparam logic [4:0] GRP_ADDCR = 5'h07;
   localparam logic [4:0] GRP_MOVRI = 5'h0f; // mov rn,#imm
   localparam logic [4:0] GRP_SUBBAR = 5'h13;
   localparam logic [4:0] GRP_XCHAR = 5'h19;
   localparam logic [4:0] GRP_DJNZR = 5'h1b;
   localparam logic [4:0] GRP_MOVAR = 5'h1d; // mov a,rn
   localparam logic [4:0] GRP_MOVRA = 5'h1f; // mov rn,a

   ////////////////////////////////////////////////////////////////////////////
   // sequencer states

   localparam logic [2:0] SM_FETCH   = 3'd0;
   localparam logic [2:0] SM_DECODE0 = 3'd1;
   localparam logic [2:0] SM_DECODE1 = 3'd2;
   localparam logic [2:0] SM_DECODE2 = 3'd3;
   localparam logic [2:0] SM_EXECUTE = 3'd4;

   // one opcode byte, read whole or as group plus register index
   typedef union packed {
      logic [7:0] full;
      struct packed {
         logic [4:0] grp;
         logic [2:0] rn;
      } split;
   } opcode_u;

   // bytes per instruction, opcode included
   function automatic logic [1:0] instr_len(input opcode_u op);
      logic [1:0] len;
      len = 2'd1;
      case (op.full)
         OP_LJMP, OP_CJNEAI: len = 2'd3;
         OP_ADDAI, OP_ADDCI, OP_SUBBAI, OP_ANLAI, OP_ORLAI, OP_XRLAI, OP_MOVAI,
         OP_SJMP, OP_JC, OP_JNC, OP_JZ, OP_JNZ: len = 2'd2;
         default: ;
      endcase
      if ((op.split.grp == GRP_MOVRI) || (op.split.grp == GRP_DJNZR)) len = 2'd2;
      return len;
   endfunction

endpackage

`default_nettype wire

// ==== uart_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_loader
   import mem_map_pkg::*;
(
   input  wire                  i_clk,
   input  wire                  i_nrst,
   input  wire                  i_uart_rx,
   output logic                 o_code_wr,
   output logic [7:0]           o_code_data,
   output logic [CODE_AW-1:0]   o_load_addr,
   output logic                 o_load_done
);

   logic [1:0]                            rx_sync;
   logic                                  rx;
   logic                                  busy;      // inside a frame
   logic [3:0]                            bit_idx;   // 0 start, 1..8 data, 9 stop
   logic [$clog2(UART_CLKS_PER_BIT)-1:0]  bit_clk;
   logic                                  sample;
   logic                                  data_bit;
   logic                                  stop_bit;

   ////////////////////////////////////////////////////////////////////////////
   // receiver

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) rx_sync <= 2'b11;           // line idles high
      else         rx_sync <= {rx_sync[0], i_uart_rx};
   end

   assign rx = rx_sync[1];

   // start bit checked at half a bit, the rest one bit apart
   assign sample   = busy & ((bit_idx == 4'd0) ? (bit_clk == (UART_CLKS_PER_BIT / 2 - 1))
                                               : (bit_clk == (UART_CLKS_PER_BIT - 1)));
   assign stop_bit = (bit_idx == 4'd9);
   assign data_bit = (bit_idx != 4'd0) & ~stop_bit;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         busy    <= 1'b0;
         bit_idx <= '0;
         bit_clk <= '0;
      end else if (!busy) begin
         bit_clk <= '0;
         bit_idx <= '0;
         if (!rx) busy <= 1'b1;                // start edge
      end else if (sample) begin
         bit_clk <= '0;
         bit_idx <= bit_idx + 4'd1;
         // glitch on the start bit, or frame complete
         if (((bit_idx == 4'd0) & rx) | stop_bit) busy <= 1'b0;
      end else begin
         bit_clk <= bit_clk + 1'b1;
      end
   end

   always_ff @(posedge i_clk) begin
      if (sample & data_bit) o_code_data <= {rx, o_code_data[7:1]}; // lsb first
   end

   ////////////////////////////////////////////////////////////////////////////
   // code memory writes

   assign o_code_wr = sample & stop_bit & ~o_load_done;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_load_addr <= '0;
         o_load_done <= 1'b0;
      end else if (o_code_wr) begin
         o_load_addr <= o_load_addr + 1'b1;
         if (o_load_addr == CODE_AW'(LOAD_BYTES - 1)) o_load_done <= 1'b1; // last byte
      end
   end

endmodule

`default_nettype wire

// ==== fetch_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_sequencer
   import mem_map_pkg::*;
   import cpu_isa_pkg::*;
(
   input  wire                  i_clk,
   input  wire                  i_nrst,
   input  wire                  i_load_done,
   input  wire  [CODE_AW-1:0]   i_load_addr,
   input  wire  [7:0]           i_code_data,
   input  wire                  i_br_taken,
   input  wire  [CODE_AW-1:0]   i_br_target,
   output logic [CODE_AW-1:0]   o_code_addr,
   output logic [CODE_AW-1:0]   o_pc_next,
   output opcode_u              o_op,
   output logic [7:0]           o_imm1,
   output logic [7:0]           o_imm2,
   output logic                 o_exec
);

   logic [2:0]          state;
   logic [2:0]          state_next;
   logic [CODE_AW-1:0]  pc;
   logic [CODE_AW-1:0]  pc_new;
   opcode_u             code_op;    // opcode as it arrives from memory
   logic [1:0]          len_new;
   logic [1:0]          len_op;

   assign code_op = i_code_data;
   assign len_new = instr_len(code_op);
   assign len_op  = instr_len(o_op);

   ////////////////////////////////////////////////////////////////////////////
   // state and program counter

   always_comb begin
      state_next = state;
      pc_new     = pc;
      case (state)
         SM_FETCH: begin
            if (i_load_done) begin             // wait for the program image
               state_next = SM_DECODE0;
               pc_new     = pc + 1'b1;
            end
         end
         SM_DECODE0: begin
            if (len_new != 2'd1) begin
               state_next = SM_DECODE1;
               pc_new     = pc + 1'b1;
            end else begin
               state_next = SM_EXECUTE;
            end
         end
         SM_DECODE1: begin
            if (len_op == 2'd3) begin
               state_next = SM_DECODE2;
               pc_new     = pc + 1'b1;
            end else begin
               state_next = SM_EXECUTE;
            end
         end
         SM_DECODE2: state_next = SM_EXECUTE;
         SM_EXECUTE: begin
            state_next = SM_FETCH;
            if (i_br_taken) pc_new = i_br_target; // else pc is already past the instr
         end
         default: state_next = SM_FETCH;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= SM_FETCH;
         pc    <= '0;
         o_op  <= '0;                          // nop until first decode
      end else begin
         state <= state_next;
         pc    <= pc_new;
         if (state == SM_DECODE0) o_op <= code_op;
      end
   end

   // operand bytes
   always_ff @(posedge i_clk) begin
      if (state == SM_DECODE1) o_imm1 <= i_code_data;
      if (state == SM_DECODE2) o_imm2 <= i_code_data;
   end

   ////////////////////////////////////////////////////////////////////////////
   // outputs

   assign o_exec      = (state == SM_EXECUTE);
   assign o_pc_next   = pc;
   assign o_code_addr = i_load_done ? pc : i_load_addr; // loader owns memory first

endmodule

`default_nettype wire

// ==== acc_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module acc_alu
   import mem_map_pkg::*;
   import cpu_isa_pkg::*;
(
   input  wire                  i_clk,
   input  wire                  i_nrst,
   input  wire                  i_exec,
   input  wire  opcode_u        i_op,
   input  wire  [7:0]           i_imm1,
   input  wire  [7:0]           i_reg_rdata,
   output logic [REG_AW-1:0]    o_reg_raddr,
   output logic [REG_AW-1:0]    o_reg_waddr,
   output logic                 o_reg_wr,
   output logic [7:0]           o_reg_wdata,
   output logic [7:0]           o_acc,
   output logic                 o_acc_zero,
   output logic                 o_carry
);

   logic [7:0] opc;
   logic [4:0] grp;
   logic [7:0] acc_next;
   logic       carry_next;
   logic       is_add;
   logic       is_addc;
   logic       is_subb;
   logic       reg_src;
   logic [7:0] src;
   logic [8:0] sum9;
   logic [8:0] diff9;

   assign opc = i_op.full;
   assign grp = i_op.split.grp;

   ////////////////////////////////////////////////////////////////////////////
   // arithmetic

   assign is_addc = (opc == OP_ADDCI) | (grp == GRP_ADDCR);
   assign is_add  = (opc == OP_ADDAI) | (grp == GRP_ADDAR) | is_addc;
   assign is_subb = (opc == OP_SUBBAI) | (grp == GRP_SUBBAR);
   assign reg_src = (grp == GRP_ADDAR) | (grp == GRP_ADDCR) | (grp == GRP_SUBBAR);
   assign src     = reg_src ? i_reg_rdata : i_imm1;

   assign sum9  = {1'b0, o_acc} + {1'b0, src} + {8'd0, is_addc & o_carry};
   assign diff9 = {1'b0, o_acc} - {1'b0, src} - {8'd0, o_carry}; // bit 8 is borrow

   always_comb begin
      acc_next   = o_acc;
      carry_next = o_carry;
      case (opc)
         OP_INCA:  acc_next = o_acc + 8'd1;    // carry untouched
         OP_DECA:  acc_next = o_acc - 8'd1;
         OP_ANLAI: acc_next = o_acc & i_imm1;
         OP_ORLAI: acc_next = o_acc | i_imm1;
         OP_XRLAI: acc_next = o_acc ^ i_imm1;
         OP_MOVAI: acc_next = i_imm1;
         OP_CLRA:  acc_next = 8'd0;
         OP_CPLA:  acc_next = ~o_acc;
         OP_RL:    acc_next = {o_acc[6:0], o_acc[7]};
         OP_RLC: begin
            acc_next   = {o_acc[6:0], o_carry};
            carry_next = o_acc[7];
         end
         OP_RRC: begin
            acc_next   = {o_carry, o_acc[7:1]};
            carry_next = o_acc[0];
         end
         OP_CLRC:  carry_next = 1'b0;
         OP_SETBC: carry_next = 1'b1;
         default: ;
      endcase
      if ((grp == GRP_MOVAR) || (grp == GRP_XCHAR)) acc_next = i_reg_rdata;
      if (is_add) begin
         acc_next   = sum9[7:0];
         carry_next = sum9[8];
      end else if (is_subb) begin
         acc_next   = diff9[7:0];
         carry_next = diff9[8];
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_acc   <= 8'd0;
         o_carry <= 1'b0;
      end else if (i_exec) begin
         o_acc   <= acc_next;
         o_carry <= carry_next;
      end
   end

   assign o_acc_zero = (o_acc == 8'd0);

   ////////////////////////////////////////////////////////////////////////////
   // register bank

   assign o_reg_raddr = {REG_BANK_BASE, i_op.split.rn};
   assign o_reg_waddr = {REG_BANK_BASE, i_op.split.rn}; // same rn as the read

   assign o_reg_wr = i_exec & ((grp == GRP_MOVRI) | (grp == GRP_MOVRA) | (grp == GRP_INCR) |
                               (grp == GRP_DECR) | (grp == GRP_DJNZR) | (grp == GRP_XCHAR));

   always_comb begin
      case (grp)
         GRP_MOVRI:           o_reg_wdata = i_imm1;
         GRP_INCR:            o_reg_wdata = i_reg_rdata + 8'd1;
         GRP_DECR, GRP_DJNZR: o_reg_wdata = i_reg_rdata - 8'd1;
         default:             o_reg_wdata = o_acc; // mov r,a and xch
      endcase
   end

endmodule

`default_nettype wire

// ==== branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_unit
   import mem_map_pkg::*;
   import cpu_isa_pkg::*;
(
   input  wire  opcode_u        i_op,
   input  wire  [7:0]           i_imm1,
   input  wire  [7:0]           i_imm2,
   input  wire  [CODE_AW-1:0]   i_pc_next,
   input  wire  [7:0]           i_acc,
   input  wire                  i_acc_zero,
   input  wire                  i_carry,
   input  wire  [7:0]           i_reg_rdata,
   output logic                 o_br_taken,
   output logic [CODE_AW-1:0]   o_br_target
);

   logic [7:0]          opc;
   logic [7:0]          rel;
   logic [15:0]         abs16;
   logic [CODE_AW-1:0]  rel_target;

   assign opc = i_op.full;

   // cjne keeps its offset in the third byte
   assign rel        = (opc == OP_CJNEAI) ? i_imm2 : i_imm1;
   assign rel_target = i_pc_next + {{(CODE_AW - 8){rel[7]}}, rel}; // wraps in code space
   assign abs16      = {i_imm1, i_imm2};          // high byte first

   always_comb begin
      o_br_taken = 1'b0;
      case (opc)
         OP_SJMP, OP_LJMP: o_br_taken = 1'b1;
         OP_JZ:            o_br_taken = i_acc_zero;
         OP_JNZ:           o_br_taken = ~i_acc_zero;
         OP_JC:            o_br_taken = i_carry;
         OP_JNC:           o_br_taken = ~i_carry;
         OP_CJNEAI:        o_br_taken = (i_acc != i_imm1);
         default: ;
      endcase
      // djnz looks at rn before the decrement lands
      if (i_op.split.grp == GRP_DJNZR) o_br_taken = (i_reg_rdata != 8'd1);
   end

   assign o_br_target = (opc == OP_LJMP) ? abs16[CODE_AW-1:0] : rel_target;

endmodule

`default_nettype wire

// ==== ice51_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module ice51_core
   import mem_map_pkg::*;
   import cpu_isa_pkg::*;
(
   input  wire                  i_clk,
   input  wire                  i_nrst,
   input  wire                  i_uart_rx,
   input  wire  [7:0]           i_code_data,
   input  wire  [7:0]           i_reg_rdata,
   output logic                 o_code_wr,
   output logic [CODE_AW-1:0]   o_code_addr,
   output logic [7:0]           o_code_data,
   output logic                 o_reg_wr,
   output logic [REG_AW-1:0]    o_reg_waddr,
   output logic [7:0]           o_reg_wdata,
   output logic [REG_AW-1:0]    o_reg_raddr
);

   logic [CODE_AW-1:0]  load_addr;
   logic                load_done;
   opcode_u             op;
   logic [7:0]          imm1;
   logic [7:0]          imm2;
   logic                exec;
   logic [CODE_AW-1:0]  pc_next;
   logic [7:0]          acc;
   logic                acc_zero;
   logic                carry;
   logic                br_taken;
   logic [CODE_AW-1:0]  br_target;

   uart_loader loader0 (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_uart_rx(i_uart_rx),
      .o_code_wr(o_code_wr), .o_code_data(o_code_data),
      .o_load_addr(load_addr), .o_load_done(load_done)
   );

   fetch_sequencer seq0 (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_load_done(load_done), .i_load_addr(load_addr),
      .i_code_data(i_code_data), .i_br_taken(br_taken), .i_br_target(br_target),
      .o_code_addr(o_code_addr), .o_pc_next(pc_next), .o_op(op),
      .o_imm1(imm1), .o_imm2(imm2), .o_exec(exec)
   );

   acc_alu alu0 (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_exec(exec), .i_op(op), .i_imm1(imm1),
      .i_reg_rdata(i_reg_rdata), .o_reg_raddr(o_reg_raddr), .o_reg_waddr(o_reg_waddr),
      .o_reg_wr(o_reg_wr), .o_reg_wdata(o_reg_wdata), .o_acc(acc),
      .o_acc_zero(acc_zero), .o_carry(carry)
   );

   branch_unit br0 (
      .i_op(op), .i_imm1(imm1), .i_imm2(imm2), .i_pc_next(pc_next), .i_acc(acc),
      .i_acc_zero(acc_zero), .i_carry(carry), .i_reg_rdata(i_reg_rdata),
      .o_br_taken(br_taken), .o_br_target(br_target)
   );

endmodule

`default_nettype wire

// ==== tb_ice51_tests.svh ====
////////////////////////////////////////////////////////////////////////////
// program builder and 8051 result model

logic [7:0] prog [$];
logic [7:0] m_acc;
logic       m_cy;
logic [7:0] m_r [0:7];

function automatic logic [7:0] rnd8();
   return 8'($urandom);
endfunction

task automatic start_test(input string name);
   int r;
   test_name = name;
   prog.delete();
   exp_wr.delete();
   m_acc = 8'h00;                              // acc and carry clear at reset
   m_cy  = 1'b0;
   for (r = 0; r < 8; r++) m_r[r] = 8'h00;
endtask

task automatic emit(input logic [7:0] b);
   prog.push_back(b);
endtask

task automatic expect_wr(input logic [2:0] rn, input logic [7:0] data);
   exp_wr.push_back({REG_BANK_BASE, rn, data});
   m_r[rn] = data;
endtask

task automatic alu_imm(input logic [7:0] opc, input logic [7:0] imm);
   int r;
   emit(opc);
   emit(imm);
   case (opc)
      OP_MOVAI: m_acc = imm;
      OP_ADDAI, OP_ADDCI: begin
         r     = m_acc + imm + ((opc == OP_ADDCI) ? m_cy : 1'b0);
         m_cy  = (r > 255);
         m_acc = r[7:0];
      end
      OP_SUBBAI: begin
         r     = m_acc - imm - m_cy;           // borrow when negative
         m_cy  = (r < 0);
         m_acc = r[7:0];
      end
      OP_ANLAI: m_acc = m_acc & imm;
      OP_ORLAI: m_acc = m_acc | imm;
      OP_XRLAI: m_acc = m_acc ^ imm;
      default: ;
   endcase
endtask

task automatic alu_one(input logic [7:0] opc);
   logic old_cy;
   emit(opc);
   old_cy = m_cy;
   case (opc)
      OP_INCA:  m_acc = m_acc + 8'd1;
      OP_DECA:  m_acc = m_acc - 8'd1;
      OP_CLRA:  m_acc = 8'h00;
      OP_CPLA:  m_acc = ~m_acc;
      OP_RL:    m_acc = {m_acc[6:0], m_acc[7]};
      OP_RLC: begin
         m_cy  = m_acc[7];
         m_acc = {m_acc[6:0], old_cy};
      end
      OP_RRC: begin
         m_cy  = m_acc[0];
         m_acc = {old_cy, m_acc[7:1]};
      end
      OP_CLRC:  m_cy = 1'b0;
      OP_SETBC: m_cy = 1'b1;
      default: ;
   endcase
endtask

task automatic mov_r_a(input logic [2:0] rn);
   emit({GRP_MOVRA, rn});
   expect_wr(rn, m_acc);
endtask

task automatic mov_r_imm(input logic [2:0] rn, input logic [7:0] v);
   emit({GRP_MOVRI, rn});
   emit(v);
   expect_wr(rn, v);
endtask

// pad with sjmp to itself, load, wait for all writes, compare
task automatic run_program();
   int k;
   while (prog.size() < LOAD_BYTES) begin
      if (prog.size() == LOAD_BYTES - 1) begin
         prog.push_back(8'h00);
      end else begin
         prog.push_back(OP_SJMP);
         prog.push_back(8'hfe);
      end
   end
   reset_dut();
   for (k = 0; k < LOAD_BYTES; k++) uart_send(prog[k]);
   while (wr_log.size() < exp_wr.size()) @(posedge clk);
   check("code write count", LOAD_BYTES, load_log.size());
   for (k = 0; k < LOAD_BYTES; k++) check("code write", {CODE_AW'(k), prog[k]}, load_log[k]);
   for (k = 0; k < exp_wr.size(); k++) check("reg write", exp_wr[k], wr_log[k]);
endtask

////////////////////////////////////////////////////////////////////////////
// directed tests

task automatic test_loader();
   start_test("loader");
   mov_r_imm(3'd3, rnd8());
   run_program();
endtask

task automatic test_imm_alu();
   start_test("imm_alu");
   alu_imm(OP_MOVAI, rnd8());
   mov_r_a(3'd0);
   alu_imm(OP_ADDAI, rnd8());
   mov_r_a(3'd1);
   alu_imm(OP_SUBBAI, rnd8());                 // carry from the add feeds in
   mov_r_a(3'd2);
   alu_imm(OP_ANLAI, rnd8());
   mov_r_a(3'd3);
   alu_imm(OP_ORLAI, rnd8());
   mov_r_a(3'd3);
   alu_imm(OP_XRLAI, rnd8());
   mov_r_a(3'd4);
   alu_one(OP_INCA);
   alu_one(OP_CPLA);
   alu_one(OP_RL);
   mov_r_a(3'd5);
   alu_one(OP_DECA);
   mov_r_a(3'd6);
   alu_one(OP_CLRA);
   mov_r_a(3'd7);
   run_program();
endtask

task automatic test_carry();
   start_test("carry");
   alu_one(OP_SETBC);
   alu_imm(OP_MOVAI, rnd8());
   alu_imm(OP_ADDCI, rnd8());
   mov_r_a(3'd0);
   alu_one(OP_RLC);
   mov_r_a(3'd1);
   alu_one(OP_RRC);
   mov_r_a(3'd2);
   alu_one(OP_CLRC);
   alu_imm(OP_MOVAI, rnd8() & 8'h7f);
   alu_imm(OP_SUBBAI, rnd8() | 8'h80);         // always borrows
   mov_r_a(3'd3);
   alu_imm(OP_SUBBAI, rnd8());                 // uses the borrow just made
   mov_r_a(3'd4);
   alu_one(OP_CLRA);
   alu_one(OP_RLC);                            // carry into bit 0
   mov_r_a(3'd5);
   run_program();
endtask

task automatic test_reg();
   logic [7:0] old_acc;
   int         r;
   start_test("reg");
   mov_r_imm(3'd2, rnd8());
   emit({GRP_INCR, 3'd2});
   expect_wr(3'd2, m_r[2] + 8'd1);
   mov_r_imm(3'd3, rnd8());
   emit({GRP_DECR, 3'd3});
   expect_wr(3'd3, m_r[3] - 8'd1);
   alu_imm(OP_MOVAI, rnd8());
   emit({GRP_XCHAR, 3'd2});
   old_acc = m_acc;
   m_acc   = m_r[2];
   expect_wr(3'd2, old_acc);
   mov_r_a(3'd4);
   emit({GRP_MOVAR, 3'd3});
   m_acc = m_r[3];
   emit({GRP_ADDAR, 3'd2});
   r     = m_acc + m_r[2];
   m_cy  = (r > 255);
   m_acc = r[7:0];
   mov_r_a(3'd5);
   run_program();
endtask

task automatic test_branch();
   logic [7:0] code [0:31];
   logic [7:0] n;
   logic [7:0] k;
   int         j;
   start_test("branch");
   n = 8'd1 + 8'($urandom % 8);
   k = 8'd1 + 8'($urandom % 255);              // nonzero so cjne is taken
   code = '{
      OP_CLRA,                                 // 00 a = 0
      OP_JNZ, 8'h01,                           // 01 not taken
      {GRP_MOVRA, 3'd1},                       // 03 marker
      OP_JZ, 8'h01,                            // 04 taken
      {GRP_MOVRA, 3'd2},                       // 06 skipped
      OP_SETBC,
      OP_JNC, 8'h01,                           // 08 not taken
      {GRP_MOVRA, 3'd3},                       // 0a marker
      OP_JC, 8'h01,                            // 0b taken
      {GRP_MOVRA, 3'd4},                       // 0d skipped
      OP_CJNEAI, k, 8'h01,                     // 0e taken
      {GRP_MOVRA, 3'd5},                       // 11 skipped
      {GRP_MOVRI, 3'd6}, n,                    // 12 loop count
      {GRP_DJNZR, 3'd6}, 8'hfe,                // 14 back onto itself
      OP_CJNEAI, 8'h00, 8'h01,                 // 16 not taken
      OP_LJMP, 8'h00, 8'h1d,                   // 19 over one byte
      {GRP_MOVRA, 3'd2},                       // 1c skipped
      {GRP_MOVRA, 3'd7},                       // 1d end marker
      OP_SJMP, 8'hfd                           // 1e back to the end marker
   };
   for (j = 0; j < 32; j++) emit(code[j]);
   expect_wr(3'd1, 8'h00);
   expect_wr(3'd3, 8'h00);
   expect_wr(3'd6, n);
   for (j = 1; j <= n; j++) expect_wr(3'd6, n - 8'(j));
   expect_wr(3'd7, 8'h00);
   expect_wr(3'd7, 8'h00);
   run_program();
endtask

// ==== tb_ice51.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ice51
   import mem_map_pkg::*;
   import cpu_isa_pkg::*;
();

   localparam int          CLK_HALF    = 4;
   localparam int          NUM_TESTS   = 5;
   localparam int          CYCLE_LIMIT = NUM_TESTS * 40000; // one load is about 33k cycles
   localparam logic [31:0] SEED        = 32'h6d7d_168b;

   logic                  clk;
   logic                  nrst;
   logic                  uart_rx;
   logic [7:0]            code_rdata;
   wire  [7:0]            reg_rdata;
   wire                   code_wr;
   wire  [CODE_AW-1:0]    code_addr;
   wire  [7:0]            code_wdata;
   wire                   reg_wr;
   wire  [REG_AW-1:0]     reg_waddr;
   wire  [7:0]            reg_wdata;
   wire  [REG_AW-1:0]     reg_raddr;

   logic [7:0]            code_mem [0:(1 << CODE_AW) - 1];
   logic [7:0]            regs [0:7];
   logic [CODE_AW+7:0]    load_log [$];    // {address, data} per code write
   logic [REG_AW+7:0]     wr_log [$];      // {address, data} per register write
   logic [REG_AW+7:0]     exp_wr [$];
   string                 test_name;
   int                    cycles = 0;
   int unsigned           seed_ret;
   int                    i;

   ice51_core dut0 (
      .i_clk(clk), .i_nrst(nrst), .i_uart_rx(uart_rx),
      .i_code_data(code_rdata), .i_reg_rdata(reg_rdata),
      .o_code_wr(code_wr), .o_code_addr(code_addr), .o_code_data(code_wdata),
      .o_reg_wr(reg_wr), .o_reg_waddr(reg_waddr), .o_reg_wdata(reg_wdata),
      .o_reg_raddr(reg_raddr)
   );

   always #CLK_HALF clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // memory models

   always @(posedge clk) begin
      if (code_wr) begin
         code_mem[code_addr] <= code_wdata;
         load_log.push_back({code_addr, code_wdata});
      end
      code_rdata <= code_mem[code_addr];       // one cycle read latency
   end

   assign reg_rdata = regs[reg_raddr[2:0]];    // bank only, upper bits fixed

   always @(posedge clk) begin
      if (reg_wr) begin
         regs[reg_waddr[2:0]] <= reg_wdata;
         wr_log.push_back({reg_waddr, reg_wdata});
      end
      if (nrst) check("reg read bank", REG_BANK_BASE, reg_raddr[REG_AW-1:3]);
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: no result after %0d cycles, in test %s", CYCLE_LIMIT, test_name);
         $display("TESTS FAILED");
         $fatal(1, "run stopped by the cycle limit");
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // helpers

   task automatic check(input string what, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (expected !== actual) begin
         $display("[FAIL] %s (%s): expected %h, actual %h", test_name, what, expected, actual);
         $display("TESTS FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic reset_dut();
      int r;
      nrst    <= 1'b0;
      uart_rx <= 1'b1;
      for (r = 0; r < 8; r++) regs[r] = 8'h00;
      repeat (8) @(posedge clk);
      load_log.delete();
      wr_log.delete();
      nrst <= 1'b1;
      @(posedge clk);
   endtask

   // 8N1 frame, lsb first
   task automatic uart_send(input logic [7:0] data);
      logic [9:0] frame;
      int         b;
      frame = {1'b1, data, 1'b0};
      for (b = 0; b < 10; b++) begin
         uart_rx <= frame[b];
         repeat (UART_CLKS_PER_BIT) @(posedge clk);
      end
   endtask

   `include "tb_ice51_tests.svh"

   initial begin
      clk        = 1'b0;
      nrst       = 1'b0;
      uart_rx    = 1'b1;
      code_rdata = 8'h00;
      for (i = 0; i < 8; i++) regs[i] = 8'h00;
      seed_ret = $urandom(SEED);
      test_loader();
      test_imm_alu();
      test_carry();
      test_reg();
      test_branch();
      $display("TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
mem_map_pkg.sv
cpu_isa_pkg.sv
uart_loader.sv
fetch_sequencer.sv
acc_alu.sv
branch_unit.sv
ice51_core.sv
tb_ice51.sv
